/* analog_top.f */
+incdir+.
bus_pkg.sv
analog_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
adc_frontend.sv
dac_backend.sv
scope_capture.sv
analog_top.sv
analog_top_chk.sv
analog_top_tb.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TB_TOP     ?= analog_top_tb
DUT_TOP    ?= analog_top
FILELIST   ?= analog_top.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* analog_top_tb.sv */
// directed testbench for the analog top with bus tasks,
// reset / housekeeping / DAC / scope checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module analog_top_tb;

  import bus_pkg::*;
  import analog_pkg::*;

  localparam int        CLK_PERIOD      = 40;     // ns
  localparam int        RESET_CYCLES    = 8;
  localparam int        ACK_LIMIT       = 16;     // cycles per bus access
  localparam int        POLL_LIMIT      = 40;     // CTRL reads while waiting for done
  // six tests need a few hundred cycles in all
  localparam int        WATCHDOG_CYCLES = 2000;
  localparam int        RAND_SEED       = 32'he47d8399;
  localparam bus_addr_t HK_BASE         = 32'h0000_0000;   // region 0
  localparam bus_addr_t SC_BASE         = 32'h0010_0000;   // region 1

  logic                 adc_clk = 1'b0;
  logic                 arst_n_i;
  logic [`RP_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_PIN_W-1:0] adc_dat_b_i;
  logic                 trig_ext_i;
  bus_addr_t            sys_addr_i;
  bus_data_t            sys_wdata_i;
  bus_sel_t             sys_sel_i;
  logic                 sys_wen_i;
  logic                 sys_ren_i;
  bus_data_t            sys_rdata_o;
  logic                 sys_ack_o;
  logic                 sys_err_o;
  pin_code_t            dac_a_o;
  pin_code_t            dac_b_o;
  logic                 dac_rst_o;
  logic [7:0]           led_o;
  int                   ack_lat;   // cycles from strobe to ack of the last access

  analog_top dut_i (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .adc_dat_a_i(adc_dat_a_i),
    .adc_dat_b_i(adc_dat_b_i),
    .trig_ext_i (trig_ext_i),
    .sys_addr_i (sys_addr_i),
    .sys_wdata_i(sys_wdata_i),
    .sys_sel_i  (sys_sel_i),
    .sys_wen_i  (sys_wen_i),
    .sys_ren_i  (sys_ren_i),
    .sys_rdata_o(sys_rdata_o),
    .sys_ack_o  (sys_ack_o),
    .sys_err_o  (sys_err_o),
    .dac_a_o    (dac_a_o),
    .dac_b_o    (dac_b_o),
    .dac_rst_o  (dac_rst_o),
    .led_o      (led_o)
  );

  always #(CLK_PERIOD/2) adc_clk = ~adc_clk;

  ////////////////////////////////////////
  // expected values
  ////////////////////////////////////////

  // negative slope code keeps the msb and flips the rest
  function automatic logic [13:0] dac_code(logic [13:0] lvl);
    return lvl ^ 14'h1FFF;
  endfunction

  function automatic logic [15:0] lvl_word(logic [13:0] lvl);
    return {{2{lvl[13]}}, lvl};   // half of a buffer word
  endfunction

  // pins[15:2] carry the code over two reserved lsbs
  function automatic logic [15:0] adc_word(logic [15:0] pins);
    return lvl_word(pins[15:2] ^ 14'h1FFF);
  endfunction

  function automatic logic [31:0] sext32(logic [13:0] v);
    return {{18{v[13]}}, v};
  endfunction

  ////////////////////////////////////////
  // checks and bus access
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  // one strobe cycle then a wait for ack sampled on the falling edge
  task automatic single_access(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                               input bus_sel_t sel, output bus_data_t rdata);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    rdata  = '0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_sel_i   <= sel;
    sys_wen_i   <= we;
    sys_ren_i   <= !we;
    while (!got)
    begin
      @(negedge adc_clk);
      if (sys_ack_o)
      begin
        got     = 1'b1;
        rdata   = sys_rdata_o;
        ack_lat = waited;
        check("sys_err_o", sys_err_o, 0);
      end
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;   // address stays until the next access
      sys_ren_i <= 1'b0;
      waited++;
      if (!got && waited > ACK_LIMIT)
        stop_run("bus access never acknowledged");
    end
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata, input bus_sel_t sel);
    bus_data_t unused;
    single_access(1'b1, addr, wdata, sel, unused);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t rdata);
    single_access(1'b0, addr, '0, 4'hF, rdata);
  endtask

  // poll CTRL until the done bit shows up
  task automatic wait_done;
    bus_data_t rd;
    int        polls;
    rd    = '0;
    polls = 0;
    while (!rd[2])
    begin
      if (polls == POLL_LIMIT)
        stop_run("scope never reported capture done");
      bus_read(SC_BASE + `RP_SC_CTRL_OFS, rd);
      polls++;
    end
    check("scope ctrl after capture", rd, 32'h4);   // done only
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic apply_reset;
    @(posedge adc_clk);
    arst_n_i <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge adc_clk);
    @(negedge adc_clk);
    check("dac_rst_o in reset", dac_rst_o, 1);
    @(posedge adc_clk);
    arst_n_i <= 1'b1;
    @(negedge adc_clk);
    check("dac_rst_o after release", dac_rst_o, 1);   // one extra cycle
    @(negedge adc_clk);
    check("dac_rst_o", dac_rst_o, 0);
  endtask

  task automatic reset_state_test;
    bus_data_t rd;
    @(negedge adc_clk);
    check("led_o", led_o, 0);
    check("dac_a_o", dac_a_o, dac_code(14'd0));
    check("dac_b_o", dac_b_o, dac_code(14'd0));
    bus_read(SC_BASE + `RP_SC_CTRL_OFS, rd);
    check("scope ctrl", rd, 0);
    check("scope ack latency", ack_lat, 1);
  endtask

  task automatic housekeeping_test;
    bus_data_t rd;
    bus_read(HK_BASE + `RP_HK_ID_OFS, rd);
    check("hk id", rd, `RP_HK_ID);
    check("hk ack latency", ack_lat, 1);
    bus_write(HK_BASE + `RP_HK_LED_OFS, 32'h0000_00A5, 4'hF);
    bus_read(HK_BASE + `RP_HK_LED_OFS, rd);
    check("led reg", rd, 32'hA5);
    check("led_o", led_o, 8'hA5);
    // upper lanes only so the led byte in lane 0 holds
    bus_write(HK_BASE + `RP_HK_LED_OFS, 32'hFFFF_FF3C, 4'b1110);
    bus_read(HK_BASE + `RP_HK_LED_OFS, rd);
    check("led reg, upper lanes", rd, 32'hA5);
    bus_write(HK_BASE + `RP_HK_LED_OFS, 32'h1234_565A, 4'b0001);
    bus_read(HK_BASE + `RP_HK_LED_OFS, rd);
    check("led reg, lane 0", rd, 32'h5A);
    check("led_o", led_o, 8'h5A);
  endtask

  task automatic unused_region_test;
    bus_data_t rd;
    bus_addr_t addr;
    addr = ((2 + ($urandom % 6)) << `RP_REGION_LSB) | `RP_HK_LED_OFS;
    bus_read(addr, rd);
    check("unused region rdata", rd, 0);
    check("unused region ack latency", ack_lat, 0);   // same cycle
    bus_write(addr, 32'hFF, 4'hF);
    check("unused region ack latency", ack_lat, 0);
    bus_read(HK_BASE + `RP_HK_LED_OFS, rd);
    check("led reg after unused write", rd, 32'h5A);
  endtask

  task automatic dac_conversion_test;
    bus_data_t wd_a;
    bus_data_t wd_b;
    bus_data_t rd;
    repeat (4)
    begin
      wd_a = $urandom;
      wd_b = $urandom;
      bus_write(HK_BASE + `RP_HK_DACA_OFS, wd_a, 4'hF);
      @(negedge adc_clk);   // one cycle past the ack
      check("dac_a_o", dac_a_o, dac_code(wd_a[13:0]));
      bus_write(HK_BASE + `RP_HK_DACB_OFS, wd_b, 4'hF);
      @(negedge adc_clk);
      check("dac_b_o", dac_b_o, dac_code(wd_b[13:0]));
      bus_read(HK_BASE + `RP_HK_DACA_OFS, rd);
      check("dac level a", rd, sext32(wd_a[13:0]));
    end
  endtask

  task automatic adc_capture_test;
    logic [15:0] pins_a;
    logic [15:0] pins_b;
    bus_data_t   rd;
    pins_a = 16'($urandom);
    pins_b = 16'($urandom);
    @(posedge adc_clk);
    adc_dat_a_i <= pins_a;
    adc_dat_b_i <= pins_b;
    bus_write(SC_BASE + `RP_SC_CTRL_OFS, 32'h3, 4'hF);   // arm + sw trigger
    wait_done();
    for (int i = 0; i < `RP_SC_DEPTH; i++)
    begin
      bus_read(SC_BASE + `RP_SC_BUF_OFS + 4 * i, rd);
      check("scope buffer", rd, {adc_word(pins_b), adc_word(pins_a)});
    end
  endtask

  task automatic loopback_ext_trig_test;
    logic [13:0] lvl_a;
    logic [13:0] lvl_b;
    bus_data_t   rd;
    lvl_a = 14'($urandom);
    lvl_b = 14'($urandom);
    bus_write(HK_BASE + `RP_HK_DACA_OFS, 32'(lvl_a), 4'hF);
    bus_write(HK_BASE + `RP_HK_DACB_OFS, 32'(lvl_b), 4'hF);
    bus_write(HK_BASE + `RP_HK_LOOP_OFS, 32'h1, 4'hF);
    @(posedge adc_clk);
    adc_dat_a_i <= 16'($urandom);   // pins must not reach the buffer
    adc_dat_b_i <= 16'($urandom);
    bus_write(SC_BASE + `RP_SC_CTRL_OFS, 32'h1, 4'hF);   // arm only
    bus_read(SC_BASE + `RP_SC_CTRL_OFS, rd);
    check("scope ctrl armed", rd, 32'h1);
    @(posedge adc_clk);
    trig_ext_i <= 1'b1;
    @(posedge adc_clk);
    trig_ext_i <= 1'b0;
    wait_done();
    for (int i = 0; i < `RP_SC_DEPTH; i++)
    begin
      bus_read(SC_BASE + `RP_SC_BUF_OFS + 4 * i, rd);
      check("scope buffer, loopback", rd, {lvl_word(lvl_b), lvl_word(lvl_a)});
    end
    bus_write(HK_BASE + `RP_HK_LOOP_OFS, 32'h0, 4'hF);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    arst_n_i    = 1'b1;   // asserted on the first edge
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    trig_ext_i  = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    ack_lat     = 0;
    void'($urandom(RAND_SEED));
    apply_reset();
    reset_state_test();
    housekeeping_test();
    unused_region_test();
    dac_conversion_test();
    adc_capture_test();
    loopback_ext_trig_test();
    $display("Test passed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_run("watchdog expired, simulation took too long");
  end

endmodule

`default_nettype wire

/* analog_top_chk.sv */
// protocol assertions for the analog top, bus acks
// and the DAC reset line, bound onto analog_top
`timescale 1ns/1ps
`default_nettype none

module analog_top_chk (
  input logic adc_clk,
  input logic arst_n_i,
  input logic sys_req_i,   // wen | ren at the top
  input logic sys_ack_i,
  input logic hk_req_i,
  input logic hk_ack_i,
  input logic sc_req_i,
  input logic sc_ack_i,
  input logic dac_rst_i
);

  ////////////////////////////////////////
  // slave acks, one cycle late, one wide
  ////////////////////////////////////////

  hk_ack_late: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_req_i |=> hk_ack_i) else $error("hk ack missing after request");
  hk_ack_cause: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_ack_i |-> $past(hk_req_i)) else $error("hk ack without request");
  hk_ack_width: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_ack_i |=> !hk_ack_i) else $error("hk ack longer than one cycle");

  sc_ack_late: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sc_req_i |=> sc_ack_i) else $error("scope ack missing after request");
  sc_ack_cause: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sc_ack_i |-> $past(sc_req_i)) else $error("scope ack without request");
  sc_ack_width: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sc_ack_i |=> !sc_ack_i) else $error("scope ack longer than one cycle");

  // top ack only rises around a request
  sys_ack_cause: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $rose(sys_ack_i) |-> (sys_req_i || $past(sys_req_i)))
    else $error("bus ack rose with no request");

  dac_rst_held: assert property (@(posedge adc_clk)
    !arst_n_i |-> dac_rst_i) else $error("dac reset low during reset");

endmodule

bind analog_top analog_top_chk chk_i (
  .adc_clk  (adc_clk),
  .arst_n_i (arst_n_i),
  .sys_req_i(sys_wen_i | sys_ren_i),
  .sys_ack_i(sys_ack_o),
  .hk_req_i (wen_hk | ren_hk),
  .hk_ack_i (ack_hk),
  .sc_req_i (wen_sc | ren_sc),
  .sc_ack_i (ack_sc),
  .dac_rst_i(dac_rst_o)
);

`default_nettype wire

/* analog_top.sv */
// analog instrument top, bus decoder, housekeeping,
// ADC/DAC stages and scope capture
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module analog_top (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic [`RP_PIN_W-1:0]  adc_dat_a_i,   // ADC ch a
  input  logic [`RP_PIN_W-1:0]  adc_dat_b_i,   // ADC ch b
  input  logic                  trig_ext_i,
  input  bus_pkg::bus_addr_t    sys_addr_i,
  input  bus_pkg::bus_data_t    sys_wdata_i,
  input  bus_pkg::bus_sel_t     sys_sel_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output bus_pkg::bus_data_t    sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  output analog_pkg::pin_code_t dac_a_o,
  output analog_pkg::pin_code_t dac_b_o,
  output logic                  dac_rst_o,
  output logic [7:0]            led_o
);

  import bus_pkg::*;
  import analog_pkg::*;

  logic      wen_hk, ren_hk, ack_hk;
  logic      wen_sc, ren_sc, ack_sc;
  bus_data_t rdata_hk;
  bus_data_t rdata_sc;
  logic      loop_en;
  sample_t   dac_lvl_a, dac_lvl_b;   // housekeeping levels
  sample_t   adc_a, adc_b;           // converted samples

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////

  sys_bus_decoder dec_i (
    .sys_addr_i (sys_addr_i),
    .sys_wen_i  (sys_wen_i),
    .sys_ren_i  (sys_ren_i),
    .rdata_hk_i (rdata_hk),
    .rdata_sc_i (rdata_sc),
    .ack_hk_i   (ack_hk),
    .ack_sc_i   (ack_sc),
    .wen_hk_o   (wen_hk),
    .ren_hk_o   (ren_hk),
    .wen_sc_o   (wen_sc),
    .ren_sc_o   (ren_sc),
    .sys_rdata_o(sys_rdata_o),
    .sys_ack_o  (sys_ack_o),
    .sys_err_o  (sys_err_o)
  );

  hk_regs hk_i (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .addr_i     (sys_addr_i[`RP_REGION_LSB-1:0]),
    .wdata_i    (sys_wdata_i),
    .sel_i      (sys_sel_i),
    .wen_i      (wen_hk),
    .ren_i      (ren_hk),
    .rdata_o    (rdata_hk),
    .ack_o      (ack_hk),
    .led_o      (led_o),
    .loop_en_o  (loop_en),
    .dac_lvl_a_o(dac_lvl_a),
    .dac_lvl_b_o(dac_lvl_b)
  );

  ////////////////////////////////////////
  // analog path
  ////////////////////////////////////////

  adc_frontend adc_i (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .adc_dat_a_i(adc_dat_a_i),
    .adc_dat_b_i(adc_dat_b_i),
    .loop_en_i  (loop_en),
    .dac_lvl_a_i(dac_lvl_a),
    .dac_lvl_b_i(dac_lvl_b),
    .adc_a_o    (adc_a),
    .adc_b_o    (adc_b)
  );

  dac_backend dac_i (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .dac_lvl_a_i(dac_lvl_a),
    .dac_lvl_b_i(dac_lvl_b),
    .dac_a_o    (dac_a_o),
    .dac_b_o    (dac_b_o),
    .dac_rst_o  (dac_rst_o)
  );

  scope_capture scope_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .trig_ext_i(trig_ext_i),
    .addr_i    (sys_addr_i[`RP_REGION_LSB-1:0]),
    .wdata_i   (sys_wdata_i),
    .wen_i     (wen_sc),
    .ren_i     (ren_sc),
    .rdata_o   (rdata_sc),
    .ack_o     (ack_sc)
  );

endmodule

`default_nettype wire

/* scope_capture.sv */
// scope capture, arm / trigger control and a sample-pair
// buffer of RP_SC_DEPTH words readable over the bus
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module scope_capture (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  analog_pkg::sample_t       adc_a_i,
  input  analog_pkg::sample_t       adc_b_i,
  input  logic                      trig_ext_i,
  input  logic [`RP_REGION_LSB-1:0] addr_i,
  input  bus_pkg::bus_data_t        wdata_i,
  input  logic                      wen_i,
  input  logic                      ren_i,
  output bus_pkg::bus_data_t        rdata_o,
  output logic                      ack_o
);

  import bus_pkg::*;
  import analog_pkg::*;

  localparam int BUF_SPAN = 4 * `RP_SC_DEPTH;   // bytes

  logic      armed;
  logic      capturing;
  logic      done;
  logic      trig_ext_q;
  sc_idx_t   wr_ptr;
  bus_data_t buf_mem [`RP_SC_DEPTH];
  logic      ctrl_wr;
  logic      sw_trig;
  logic      ext_rise;
  logic      trig;
  logic      buf_hit;
  bus_data_t rd_mux;

  ////////////////////////////////////////
  // trigger logic
  ////////////////////////////////////////

  assign ctrl_wr  = wen_i && (addr_i == `RP_SC_CTRL_OFS);
  assign sw_trig  = ctrl_wr && wdata_i[1] && (wdata_i[0] || armed);   // only with arm
  assign ext_rise = trig_ext_i && !trig_ext_q;
  assign trig     = (sw_trig || (ext_rise && armed)) && !capturing;  // no retrigger

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      armed      <= 1'b0;
      capturing  <= 1'b0;
      done       <= 1'b0;
      trig_ext_q <= 1'b0;
      wr_ptr     <= '0;
      ack_o      <= 1'b0;
    end
    else
    begin
      trig_ext_q <= trig_ext_i;
      ack_o      <= wen_i | ren_i;
      if (ctrl_wr && wdata_i[0])
      begin
        armed <= 1'b1;
        done  <= 1'b0;
      end
      if (trig)
      begin
        capturing <= 1'b1;   // first sample stored next cycle
        wr_ptr    <= '0;
      end
      else if (capturing)
      begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wr_ptr == sc_idx_t'(`RP_SC_DEPTH - 1))
        begin
          capturing <= 1'b0;
          done      <= 1'b1;
          armed     <= 1'b0;
        end
      end
    end
  end

  // b in upper half, a in lower, both sign-extended
  always_ff @(posedge adc_clk)
  begin
    if (capturing)
      buf_mem[wr_ptr] <= {16'(adc_b_i), 16'(adc_a_i)};
  end

  ////////////////////////////////////////
  // bus read side
  ////////////////////////////////////////

  assign buf_hit = (addr_i >= `RP_SC_BUF_OFS) && (addr_i < `RP_SC_BUF_OFS + BUF_SPAN);

  always_comb
  begin
    rd_mux = '0;
    if (addr_i == `RP_SC_CTRL_OFS)
      rd_mux = {29'h0, done, capturing, armed};
    else if (buf_hit)
      rd_mux = buf_mem[addr_i[2 +: $bits(sc_idx_t)]];   // word index
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
      rdata_o <= rd_mux;
  end

endmodule

`default_nettype wire

/* dac_backend.sv */
// DAC output stage, two's complement to pin code
// in output registers, plus the DAC reset line
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module dac_backend (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  analog_pkg::sample_t   dac_lvl_a_i,
  input  analog_pkg::sample_t   dac_lvl_b_i,
  output analog_pkg::pin_code_t dac_a_o,
  output analog_pkg::pin_code_t dac_b_o,
  output logic                  dac_rst_o
);

  import analog_pkg::*;

  // same bit trick as the ADC side, other direction
  function automatic pin_code_t to_pin(sample_t s);
    return {s[`RP_ADC_W-1], ~s[`RP_ADC_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_a_o   <= to_pin('0);   // mid scale, 0x1FFF
      dac_b_o   <= to_pin('0);
      dac_rst_o <= 1'b1;         // held through reset
    end
    else
    begin
      dac_a_o   <= to_pin(dac_lvl_a_i);
      dac_b_o   <= to_pin(dac_lvl_b_i);
      dac_rst_o <= 1'b0;         // drops on first edge after release
    end
  end

endmodule

`default_nettype wire

/* adc_frontend.sv */
// ADC input stage, pin register, negative-slope to
// two's complement conversion, digital loopback
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module adc_frontend (
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  logic [`RP_PIN_W-1:0] adc_dat_a_i,
  input  logic [`RP_PIN_W-1:0] adc_dat_b_i,
  input  logic                 loop_en_i,
  input  analog_pkg::sample_t  dac_lvl_a_i,
  input  analog_pkg::sample_t  dac_lvl_b_i,
  output analog_pkg::sample_t  adc_a_o,
  output analog_pkg::sample_t  adc_b_o
);

  import analog_pkg::*;

  pin_code_t code_a;   // registered pin code
  pin_code_t code_b;
  sample_t   conv_a;
  sample_t   conv_b;

  // two lsbs of the 16-bit bus are reserved
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      code_a <= '0;
      code_b <= '0;
    end
    else
    begin
      code_a <= adc_dat_a_i[`RP_PIN_W-1:`RP_PIN_W-`RP_ADC_W];
      code_b <= adc_dat_b_i[`RP_PIN_W-1:`RP_PIN_W-`RP_ADC_W];
    end
  end

  // keep msb, invert the rest
  assign conv_a = {code_a[`RP_ADC_W-1], ~code_a[`RP_ADC_W-2:0]};
  assign conv_b = {code_b[`RP_ADC_W-1], ~code_b[`RP_ADC_W-2:0]};

  assign adc_a_o = loop_en_i ? dac_lvl_a_i : conv_a;   // loopback bypasses the pins
  assign adc_b_o = loop_en_i ? dac_lvl_b_i : conv_b;

endmodule

`default_nettype wire

/* hk_regs.sv */
// housekeeping registers, ID word, LEDs, loopback
// and the two DAC level registers
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module hk_regs (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  logic [`RP_REGION_LSB-1:0] addr_i,     // offset inside region
  input  bus_pkg::bus_data_t        wdata_i,
  input  bus_pkg::bus_sel_t         sel_i,
  input  logic                      wen_i,
  input  logic                      ren_i,
  output bus_pkg::bus_data_t        rdata_o,
  output logic                      ack_o,
  output logic [7:0]                led_o,
  output logic                      loop_en_o,
  output analog_pkg::sample_t       dac_lvl_a_o,
  output analog_pkg::sample_t       dac_lvl_b_o
);

  import bus_pkg::*;
  import analog_pkg::*;

  bus_data_t rd_mux;

  // byte-lane merge of a level register
  function automatic sample_t merge_lvl(sample_t cur, bus_data_t wd, bus_sel_t sel);
    sample_t nxt;
    nxt = cur;
    if (sel[0])
      nxt[7:0] = wd[7:0];
    if (sel[1])
      nxt[`RP_ADC_W-1:8] = wd[`RP_ADC_W-1:8];   // upper 6 bits only
    return nxt;
  endfunction

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_o       <= '0;
      loop_en_o   <= 1'b0;
      dac_lvl_a_o <= '0;
      dac_lvl_b_o <= '0;
      ack_o       <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;   // every request acked next cycle
      if (wen_i)
      begin
        case (addr_i)
          `RP_HK_LED_OFS:  if (sel_i[0]) led_o <= wdata_i[7:0];
          `RP_HK_LOOP_OFS: if (sel_i[0]) loop_en_o <= wdata_i[0];
          `RP_HK_DACA_OFS: dac_lvl_a_o <= merge_lvl(dac_lvl_a_o, wdata_i, sel_i);
          `RP_HK_DACB_OFS: dac_lvl_b_o <= merge_lvl(dac_lvl_b_o, wdata_i, sel_i);
          default: ;   // ID and holes are read-only
        endcase
      end
    end
  end

  // read decode, levels sign-extended
  always_comb
  begin
    rd_mux = '0;
    case (addr_i)
      `RP_HK_ID_OFS:   rd_mux = `RP_HK_ID;
      `RP_HK_LED_OFS:  rd_mux = {24'h0, led_o};
      `RP_HK_LOOP_OFS: rd_mux = {31'h0, loop_en_o};
      `RP_HK_DACA_OFS: rd_mux = {{(`RP_BUS_DW-`RP_ADC_W){dac_lvl_a_o[`RP_ADC_W-1]}}, dac_lvl_a_o};
      `RP_HK_DACB_OFS: rd_mux = {{(`RP_BUS_DW-`RP_ADC_W){dac_lvl_b_o[`RP_ADC_W-1]}}, dac_lvl_b_o};
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
      rdata_o <= rd_mux;
  end

endmodule

`default_nettype wire

/* sys_bus_decoder.sv */
// system bus decoder, 8 regions on addr[22:20]
// routes strobes out and the selected answer back
`timescale 1ns/1ps
`default_nettype none

`include "rp_defs.svh"

module sys_bus_decoder (
  input  bus_pkg::bus_addr_t sys_addr_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  input  bus_pkg::bus_data_t rdata_hk_i,
  input  bus_pkg::bus_data_t rdata_sc_i,
  input  logic               ack_hk_i,
  input  logic               ack_sc_i,
  output logic               wen_hk_o,
  output logic               ren_hk_o,
  output logic               wen_sc_o,
  output logic               ren_sc_o,
  output bus_pkg::bus_data_t sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o
);

  import bus_pkg::*;

  region_t                region;
  logic [`RP_REGIONS-1:0] cs;       // one-hot chip select
  logic                   req;

  assign region = sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign cs     = {{(`RP_REGIONS-1){1'b0}}, 1'b1} << region;
  assign req    = sys_wen_i | sys_ren_i;

  // strobes only reach the addressed slave
  assign wen_hk_o = sys_wen_i & cs[0];
  assign ren_hk_o = sys_ren_i & cs[0];
  assign wen_sc_o = sys_wen_i & cs[1];
  assign ren_sc_o = sys_ren_i & cs[1];

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////

  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    if (cs[0])
    begin
      sys_rdata_o = rdata_hk_i;
      sys_ack_o   = ack_hk_i;
    end
    else if (cs[1])
    begin
      sys_rdata_o = rdata_sc_i;
      sys_ack_o   = ack_sc_i;
    end
    else
    begin
      sys_ack_o = req & (|cs[`RP_REGIONS-1:2]);   // empty regions, ack at once
    end
  end

  assign sys_err_o = 1'b0;   // no slave reports errors

endmodule

`default_nettype wire

/* analog_pkg.sv */
// analog side types, ADC/DAC samples, pin codes
// and the scope buffer index
`default_nettype none

`include "rp_defs.svh"

package analog_pkg;

  // two's complement sample, used inside the fabric
  typedef logic signed [`RP_ADC_W-1:0] sample_t;

  // unsigned negative-slope code, as on the converter pins
  typedef logic [`RP_ADC_W-1:0] pin_code_t;

  // scope write / read pointer
  typedef logic [$clog2(`RP_SC_DEPTH)-1:0] sc_idx_t;

endpackage

`default_nettype wire

/* bus_pkg.sv */
// system bus types, address and data words,
// byte select and region index
`default_nettype none

`include "rp_defs.svh"

package bus_pkg;

  // full 32-bit address as seen by the master
  typedef logic [`RP_BUS_AW-1:0] bus_addr_t;

  typedef logic [`RP_BUS_DW-1:0] bus_data_t;   // read / write word

  // one bit per byte lane
  typedef logic [`RP_BUS_DW/8-1:0] bus_sel_t;

  // region = addr[22:20]
  typedef logic [`RP_REGION_MSB-`RP_REGION_LSB:0] region_t;

endpackage

`default_nettype wire

/* rp_defs.svh */
// shared widths, address map and register offsets
// for the analog instrument core
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// sample and pin widths
`define RP_ADC_W        14
`define RP_PIN_W        16

// system bus
`define RP_BUS_AW       32
`define RP_BUS_DW       32
`define RP_REGIONS      8
`define RP_REGION_LSB   20
`define RP_REGION_MSB   22

// housekeeping, region 0
`define RP_HK_ID        32'h5250_0001
`define RP_HK_ID_OFS    'h00
`define RP_HK_LED_OFS   'h04
`define RP_HK_LOOP_OFS  'h08
`define RP_HK_DACA_OFS  'h0C
`define RP_HK_DACB_OFS  'h10

// scope, region 1
`define RP_SC_CTRL_OFS  'h000
`define RP_SC_BUF_OFS   'h100   // one word per sample pair
`define RP_SC_DEPTH     16

`endif
